//--- verilog/cpuPkg.sv
`default_nettype none

// Datapath-wide definitions shared by the execute slice and its testbench
package cpuPkg;

    // Register number width: 32 registers, r0 reads as zero
    localparam int regAddrWidth = 5;

    // ALU operation select, driven by decode as aluCtrlE
    typedef enum logic [2:0] {
        opAdd = 3'd0,   // a + b, wraps
        opSub = 3'd1,   // a - b, wraps
        opAnd = 3'd2,
        opOr  = 3'd3,
        opXor = 3'd4,
        opSlt = 3'd5,   // Signed a < b gives 1
        opSll = 3'd6,   // Shift by b[3:0]
        opSrl = 3'd7    // Logical shift by b[3:0]
    } aluOp;

    // Branch compare is done as opSub followed by a test of the zero flag,
    // so no separate compare opcode is needed

endpackage : cpuPkg

`default_nettype wire

//--- verilog/ctrlPkg.sv
`default_nettype none

// Pipeline control encodings
package ctrlPkg;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        fwdReg = 2'd0,  // Value read by decode
        fwdWb  = 2'd1,  // Writeback result
        fwdMem = 2'd2   // ALU result sitting in the memory stage
    } fwdSel;

    // Writeback value source
    typedef enum logic {srcAlu = 1'b0, srcMem = 1'b1} resultSrc;

endpackage : ctrlPkg

`default_nettype wire

//--- verilog/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit #(
    parameter int dataWidth = 18
) (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  cpuPkg::aluOp         op,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);
    import cpuPkg::*;

    logic [3:0] shamt;
    logic       lessThan;

    assign shamt    = b[3:0];                    // Only the low 4 bits shift
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            opAdd: result = a + b;
            opSub: result = a - b;
            opAnd: result = a & b;
            opOr:  result = a | b;
            opXor: result = a ^ b;
            opSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
            opSll: result = a << shamt;
            opSrl: result = a >> shamt;
            default: result = '0;
        endcase
    end

    // Used by the branch decision in execute
    assign zero = (result == '0);

endmodule : aluUnit

`default_nettype wire

//--- verilog/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  logic [cpuPkg::regAddrWidth-1:0] rs1E,
    input  logic [cpuPkg::regAddrWidth-1:0] rs2E,
    input  logic [cpuPkg::regAddrWidth-1:0] rdM,
    input  logic [cpuPkg::regAddrWidth-1:0] rdW,
    input  logic                            regWriteM,
    input  logic                            regWriteW,
    output ctrlPkg::fwdSel                  fwdAE,
    output ctrlPkg::fwdSel                  fwdBE
);
    import ctrlPkg::*;

    logic memLive;  // Memory stage will write a real register
    logic wbLive;

    assign memLive = regWriteM && (rdM != '0);
    assign wbLive  = regWriteW && (rdW != '0);

    // Newer result in memory takes priority over writeback
    always_comb begin
        if (memLive && (rdM == rs1E)) fwdAE = fwdMem;
        else if (wbLive && (rdW == rs1E)) fwdAE = fwdWb;
        else fwdAE = fwdReg;
    end

    always_comb begin
        if (memLive && (rdM == rs2E)) fwdBE = fwdMem;
        else if (wbLive && (rdW == rs2E)) fwdBE = fwdWb;
        else fwdBE = fwdReg;
    end

endmodule : forwardUnit

`default_nettype wire

//--- verilog/execStage.sv
`timescale 1ns/1ps
`default_nettype none

module execStage #(
    parameter int dataWidth = 18,
    parameter int pcWidth   = 9
) (
    input  logic                            clk,
    input  logic                            rst,
    // Control from decode
    input  logic                            regWriteE,
    input  logic                            memWriteE,
    input  logic                            aluSrcE,
    input  logic                            branchE,
    input  logic                            jumpE,
    input  logic                            flushE,
    input  ctrlPkg::resultSrc               resultSrcE,
    input  cpuPkg::aluOp                    aluCtrlE,
    // Operands
    input  logic [dataWidth-1:0]            rd1E,
    input  logic [dataWidth-1:0]            rd2E,
    input  logic [dataWidth-1:0]            immE,
    input  logic [dataWidth-1:0]            resultW,
    input  logic [pcWidth-1:0]              pcE,
    input  logic [cpuPkg::regAddrWidth-1:0] rdE,
    input  ctrlPkg::fwdSel                  fwdAE,
    input  ctrlPkg::fwdSel                  fwdBE,
    // Branch resolution, same cycle
    output logic                            pcSrcE,
    output logic [pcWidth-1:0]              pcTargetE,
    // Memory stage
    output logic                            regWriteM,
    output logic                            memWriteM,
    output ctrlPkg::resultSrc               resultSrcM,
    output logic [cpuPkg::regAddrWidth-1:0] rdM,
    output logic [dataWidth-1:0]            aluResultM,
    output logic [dataWidth-1:0]            writeDataM
);
    import ctrlPkg::*;

    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcBFwd;  // Forwarded rs2, also the store data
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluResultE;
    logic                 zeroE;

    // Three-way operand select shared by both ALU inputs
    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSel                sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] wbVal,
        input logic [dataWidth-1:0] memVal
    );
        case (sel)
            fwdWb:   return wbVal;
            fwdMem:  return memVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA    = fwdMux(fwdAE, rd1E, resultW, aluResultM);
    assign srcBFwd = fwdMux(fwdBE, rd2E, resultW, aluResultM);
    assign srcB    = aluSrcE ? immE : srcBFwd;

    aluUnit #(.dataWidth(dataWidth)) alu (
        .a      (srcA),
        .b      (srcB),
        .op     (aluCtrlE),
        .result (aluResultE),
        .zero   (zeroE)
    );

    assign pcSrcE    = (zeroE & branchE) | jumpE;
    assign pcTargetE = pcE + immE[pcWidth-1:0];  // Wraps at the PC width

    // Execute to memory register; a flush leaves a bubble behind
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= srcAlu;
            rdM        <= '0;
            aluResultM <= '0;
            writeDataM <= '0;
        end else begin
            regWriteM  <= regWriteE & ~flushE;
            memWriteM  <= memWriteE & ~flushE;
            resultSrcM <= resultSrcE;
            rdM        <= rdE;
            aluResultM <= aluResultE;
            writeDataM <= srcBFwd;  // Taken before the immediate mux
        end
    end

endmodule : execStage

`default_nettype wire

//--- verilog/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteback #(
    parameter int dataWidth = 18,
    parameter int memDepth  = 32
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            regWriteM,
    input  logic                            memWriteM,
    input  ctrlPkg::resultSrc               resultSrcM,
    input  logic [cpuPkg::regAddrWidth-1:0] rdM,
    input  logic [dataWidth-1:0]            aluResultM,
    input  logic [dataWidth-1:0]            writeDataM,
    output logic [dataWidth-1:0]            resultW,
    output logic [cpuPkg::regAddrWidth-1:0] rdW,
    output logic                            regWriteW
);
    import ctrlPkg::*;

    localparam int addrWidth = $clog2(memDepth);

    logic [dataWidth-1:0] mem [memDepth];
    logic [addrWidth-1:0] addrM;
    logic [dataWidth-1:0] readDataW;
    logic [dataWidth-1:0] aluResultW;
    resultSrc             resultSrcW;

    assign addrM = aluResultM[addrWidth-1:0];  // Word address, upper bits ignored

    // Data memory starts cleared so unwritten words load as zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < memDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (memWriteM) begin
            mem[addrM] <= writeDataM;
        end
    end

    // Memory to writeback register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteW  <= 1'b0;
            resultSrcW <= srcAlu;
            rdW        <= '0;
            aluResultW <= '0;
            readDataW  <= '0;
        end else begin
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
            rdW        <= rdM;
            aluResultW <= aluResultM;
            readDataW  <= mem[addrM];  // Registered read
        end
    end

    assign resultW = (resultSrcW == srcMem) ? readDataW : aluResultW;

endmodule : memWriteback

`default_nettype wire

//--- verilog/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore #(
    parameter int dataWidth = 18,
    parameter int pcWidth   = 9,
    parameter int memDepth  = 32
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            regWriteE,
    input  logic                            memWriteE,
    input  ctrlPkg::resultSrc               resultSrcE,
    input  logic                            aluSrcE,
    input  logic                            branchE,
    input  logic                            jumpE,
    input  logic                            flushE,
    input  cpuPkg::aluOp                    aluCtrlE,
    input  logic [dataWidth-1:0]            rd1E,
    input  logic [dataWidth-1:0]            rd2E,
    input  logic [dataWidth-1:0]            immE,
    input  logic [pcWidth-1:0]              pcE,
    input  logic [cpuPkg::regAddrWidth-1:0] rs1E,
    input  logic [cpuPkg::regAddrWidth-1:0] rs2E,
    input  logic [cpuPkg::regAddrWidth-1:0] rdE,
    output logic                            pcSrcE,
    output logic [pcWidth-1:0]              pcTargetE,
    output logic [dataWidth-1:0]            resultW,
    output logic [cpuPkg::regAddrWidth-1:0] rdW,
    output logic                            regWriteW
);
    ctrlPkg::fwdSel                  fwdAE;
    ctrlPkg::fwdSel                  fwdBE;
    logic                            regWriteM;
    logic                            memWriteM;
    ctrlPkg::resultSrc               resultSrcM;
    logic [cpuPkg::regAddrWidth-1:0] rdM;
    logic [dataWidth-1:0]            aluResultM;
    logic [dataWidth-1:0]            writeDataM;

    forwardUnit fwd (
        .rs1E, .rs2E, .rdM, .rdW, .regWriteM, .regWriteW, .fwdAE, .fwdBE
    );

    execStage #(.dataWidth(dataWidth), .pcWidth(pcWidth)) exec (
        .clk, .rst,
        .regWriteE, .memWriteE, .aluSrcE, .branchE, .jumpE, .flushE,
        .resultSrcE, .aluCtrlE,
        .rd1E, .rd2E, .immE, .resultW, .pcE, .rdE, .fwdAE, .fwdBE,
        .pcSrcE, .pcTargetE,
        .regWriteM, .memWriteM, .resultSrcM, .rdM, .aluResultM, .writeDataM
    );

    memWriteback #(.dataWidth(dataWidth), .memDepth(memDepth)) memWb (
        .clk, .rst,
        .regWriteM, .memWriteM, .resultSrcM, .rdM, .aluResultM, .writeDataM,
        .resultW, .rdW, .regWriteW
    );

endmodule : execCore

`default_nettype wire

//--- dv/execCore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreChk #(
    parameter int dataWidth = 18,
    parameter int pcWidth   = 9
) (
    input logic                            clk,
    input logic                            rst,
    input logic [cpuPkg::regAddrWidth-1:0] rs1E, rs2E, rdM, rdW,
    input logic                            regWriteM, memWriteM, regWriteW,
    input logic                            branchE, jumpE, flushE, pcSrcE,
    input logic [dataWidth-1:0]            immE,
    input logic [pcWidth-1:0]              pcE, pcTargetE,
    input ctrlPkg::fwdSel                  fwdAE, fwdBE
);
    import cpuPkg::*;
    import ctrlPkg::*;

    int failCount = 0;

    // Memory stage first, then writeback, never r0
    function automatic fwdSel expectSel(input logic [regAddrWidth-1:0] rs, rdMem, rdWb,
                                        input logic wrMem, wrWb);
        if (wrMem && rdMem != '0 && rdMem == rs) return fwdMem;
        if (wrWb && rdWb != '0 && rdWb == rs) return fwdWb;
        return fwdReg;
    endfunction

    aFwd: assert property (@(posedge clk) disable iff (!rst)
        fwdAE == expectSel(rs1E, rdM, rdW, regWriteM, regWriteW) &&
        fwdBE == expectSel(rs2E, rdM, rdW, regWriteM, regWriteW))
        else begin
            failCount++;
            $error("Forwarding select differs from the priority rule");
        end

    // Without a branch only a jump redirects the PC
    aPcSrc: assert property (@(posedge clk) disable iff (!rst) !branchE |-> pcSrcE == jumpE)
        else begin
            failCount++;
            $error("pcSrcE set without a branch or clear on a jump");
        end

    aTarget: assert property (@(posedge clk) disable iff (!rst)
        pcTargetE == pcWidth'(pcE + immE))
        else begin
            failCount++;
            $error("pcTargetE is not pcE plus the immediate");
        end

    aFlush: assert property (@(posedge clk) disable iff (!rst)
        flushE |=> (!regWriteM && !memWriteM) ##1 !regWriteW)
        else begin
            failCount++;
            $error("Flushed instruction still carries a write enable");
        end

    // Every edge seen in reset leaves the enables cleared, up to the first edge after it
    aReset: assert property (@(posedge clk)
        !rst |=> !regWriteM && !memWriteM && !regWriteW)
        else begin
            failCount++;
            $error("Write enable high during or right after reset");
        end

endmodule : execCoreChk

bind execCore execCoreChk #(.dataWidth(dataWidth), .pcWidth(pcWidth)) chk (.*);

`default_nettype wire

//--- dv/execCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;
    import cpuPkg::*;
    import ctrlPkg::*;

    localparam int dataWidth = 18;
    localparam int pcWidth   = 9;
    localparam int memDepth  = 32;
    // Init 31, random 48, forwarding 6, branch 4, memory 6, flush 4, drain 2
    localparam int numInstr   = 31 + 48 + 6 + 4 + 6 + 4 + 2;
    localparam int cycleLimit = numInstr + 20;

    logic                    clk = 1'b0;
    logic                    rst = 1'b0;
    logic                    regWriteE = 1'b0, memWriteE = 1'b0, aluSrcE = 1'b0;
    logic                    branchE = 1'b0, jumpE = 1'b0, flushE = 1'b0;
    resultSrc                resultSrcE = srcAlu;
    aluOp                    aluCtrlE = opAdd;
    logic [dataWidth-1:0]    rd1E = '0, rd2E = '0, immE = '0;
    logic [pcWidth-1:0]      pcE = '0;
    logic [regAddrWidth-1:0] rs1E = '0, rs2E = '0, rdE = '0;
    logic                    pcSrcE, regWriteW;
    logic [pcWidth-1:0]      pcTargetE;
    logic [dataWidth-1:0]    resultW;
    logic [regAddrWidth-1:0] rdW;

    logic [dataWidth-1:0] arch [32] = '{default: '0};        // Program-order registers
    logic [dataWidth-1:0] rf [32] = '{default: '0};          // What decode reads
    logic [dataWidth-1:0] dmem [memDepth] = '{default: '0};
    logic [31:0]          lfsr = 32'h6cf6fe5e;
    int                   errors = 0;
    int                   cycles = 0;

    // Instructions in flight, oldest first
    string                   pendName [$];
    logic [dataWidth-1:0]    pendVal [$];
    logic [regAddrWidth-1:0] pendRd [$];
    logic                    pendWr [$];
    logic                    pendChk [$];

    execCore #(.dataWidth(dataWidth), .pcWidth(pcWidth), .memDepth(memDepth)) i_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [dataWidth-1:0] aluModel(input aluOp op,
                                                      input logic [dataWidth-1:0] a, b);
        logic lt;
        // Signs differ: the negative one is smaller
        lt = (a[dataWidth-1] != b[dataWidth-1]) ? a[dataWidth-1] : (a < b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSlt:   return dataWidth'(lt);
            opSll:   return a << b[3:0];
            default: return a >> b[3:0];
        endcase
    endfunction

    task automatic checkOldest();
        string                   name;
        logic [dataWidth-1:0]    val;
        logic [regAddrWidth-1:0] rd;
        logic                    wr;
        logic                    chk;
        name = pendName.pop_front();
        val  = pendVal.pop_front();
        rd   = pendRd.pop_front();
        wr   = pendWr.pop_front();
        chk  = pendChk.pop_front();
        if (chk) begin
            assert (resultW === val) else begin
                errors++;
                $display("Fail %s: resultW expected %h, actual %h", name, val, resultW);
            end
            assert ({regWriteW, rdW} === {wr, rd}) else begin
                errors++;
                $display("Fail %s: {regWriteW, rdW} expected %h, actual %h",
                         name, {wr, rd}, {regWriteW, rdW});
            end
        end
        if (wr && rd != '0) rf[rd] = val;  // Register file write at writeback
    endtask

    task automatic issue(input string name, input aluOp op,
                         input logic [regAddrWidth-1:0] rs1, rs2, rd,
                         input logic [dataWidth-1:0] imm, input logic useImm, regWr, memWr,
                         input logic load, br, jmp, fl);
        logic [dataWidth-1:0]        res;
        logic [dataWidth-1:0]        wbVal;
        logic [$clog2(memDepth)-1:0] addr;
        logic                        expPcSrc;
        res      = aluModel(op, arch[rs1], useImm ? imm : arch[rs2]);
        addr     = res[$clog2(memDepth)-1:0];
        wbVal    = load ? dmem[addr] : res;
        expPcSrc = (br && res == '0) || jmp;
        @(posedge clk);
        regWriteE  <= regWr;
        memWriteE  <= memWr;
        resultSrcE <= load ? srcMem : srcAlu;
        aluSrcE    <= useImm;
        branchE    <= br;
        jumpE      <= jmp;
        flushE     <= fl;
        aluCtrlE   <= op;
        rd1E       <= rf[rs1];  // Stale for distances 1 and 2
        rd2E       <= rf[rs2];
        immE       <= imm;
        pcE        <= pcWidth'(randBits(pcWidth));
        rs1E       <= rs1;
        rs2E       <= rs2;
        rdE        <= rd;
        pendName.push_back(name);
        pendVal.push_back(wbVal);
        pendRd.push_back(rd);
        pendWr.push_back(regWr && !fl);
        pendChk.push_back(!fl);
        if (!fl && memWr) dmem[addr] = arch[rs2];
        if (!fl && regWr && rd != '0) arch[rd] = wbVal;
        @(negedge clk);
        assert (pcSrcE === expPcSrc) else begin
            errors++;
            $display("Fail %s: pcSrcE expected %b, actual %b", name, expPcSrc, pcSrcE);
        end
        if (pendName.size() == 3) checkOldest();
    endtask

    task automatic aluInstr(input string name, input aluOp op,
                            input logic [regAddrWidth-1:0] rs1, rs2, rd,
                            input logic [dataWidth-1:0] imm, input logic useImm);
        issue(name, op, rs1, rs2, rd, imm, useImm, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        for (int r = 1; r < 32; r++)
            aluInstr("init", opAdd, 5'd0, 5'd0, 5'(r), dataWidth'(randBits(dataWidth)), 1'b1);
        for (int i = 0; i < 48; i++)
            aluInstr("alu", aluOp'(3'(i)), 5'(randBits(5)), 5'(randBits(5)), 5'(randBits(5)),
                     dataWidth'(randBits(dataWidth)), randBits(1) == 32'd1);
        aluInstr("fwd", opAdd, 5'd0, 5'd0, 5'd5, 18'h0abcd, 1'b1);
        aluInstr("fwd", opAdd, 5'd5, 5'd5, 5'd6, 18'd0, 1'b0);   // Both from memory stage
        aluInstr("fwd", opSub, 5'd6, 5'd5, 5'd7, 18'd0, 1'b0);   // Memory and writeback
        aluInstr("fwd", opXor, 5'd5, 5'd7, 5'd8, 18'd0, 1'b0);
        aluInstr("fwdZero", opAdd, 5'd0, 5'd0, 5'd0, 18'h155, 1'b1);
        aluInstr("fwdZero", opOr, 5'd0, 5'd0, 5'd9, 18'd0, 1'b0);  // r0 still zero
        aluInstr("branch", opAdd, 5'd0, 5'd0, 5'd10, 18'h77, 1'b1);
        issue("beqTaken", opSub, 5'd10, 5'd10, 5'd0, 18'h3f00f, 1'b0, 1'b0, 1'b0, 1'b0,
              1'b1, 1'b0, 1'b0);
        issue("beqNotTaken", opSub, 5'd5, 5'd6, 5'd0, 18'h00123, 1'b0, 1'b0, 1'b0, 1'b0,
              1'b1, 1'b0, 1'b0);
        issue("jump", opAnd, 5'd5, 5'd6, 5'd0, 18'h1fe01, 1'b0, 1'b0, 1'b0, 1'b0,
              1'b0, 1'b1, 1'b0);
        aluInstr("mem", opAdd, 5'd0, 5'd0, 5'd11, 18'd5, 1'b1);
        aluInstr("mem", opAdd, 5'd0, 5'd0, 5'd12, dataWidth'(randBits(dataWidth)), 1'b1);
        issue("store", opAdd, 5'd11, 5'd12, 5'd0, 18'd0, 1'b1, 1'b0, 1'b1, 1'b0,
              1'b0, 1'b0, 1'b0);
        issue("load", opAdd, 5'd11, 5'd0, 5'd13, 18'd0, 1'b1, 1'b1, 1'b0, 1'b1,
              1'b0, 1'b0, 1'b0);
        issue("loadUnwritten", opAdd, 5'd0, 5'd0, 5'd14, 18'd20, 1'b1, 1'b1, 1'b0, 1'b1,
              1'b0, 1'b0, 1'b0);
        aluInstr("mem", opAdd, 5'd13, 5'd0, 5'd15, 18'd0, 1'b0);  // Load data via writeback
        issue("flushStore", opAdd, 5'd0, 5'd12, 5'd0, 18'd7, 1'b1, 1'b0, 1'b1, 1'b0,
              1'b0, 1'b0, 1'b1);
        issue("flushWrite", opAdd, 5'd0, 5'd0, 5'd12, 18'h01111, 1'b1, 1'b1, 1'b0, 1'b0,
              1'b0, 1'b0, 1'b1);
        issue("flushLoad", opAdd, 5'd0, 5'd0, 5'd16, 18'd7, 1'b1, 1'b1, 1'b0, 1'b1,
              1'b0, 1'b0, 1'b0);
        aluInstr("flush", opOr, 5'd12, 5'd0, 5'd17, 18'd0, 1'b0);  // Old r12 expected
        aluInstr("drain", opAdd, 5'd0, 5'd0, 5'd0, 18'd0, 1'b0);
        aluInstr("drain", opAdd, 5'd0, 5'd0, 5'd0, 18'd0, 1'b0);
        $display("Errors: %0d scoreboard, %0d assertion", errors, i_dut.chk.failCount);
        if (errors == 0 && i_dut.chk.failCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : execCoreTb

`default_nettype wire

//--- tb.f
verilog/cpuPkg.sv
verilog/ctrlPkg.sv
verilog/aluUnit.sv
verilog/forwardUnit.sv
verilog/execStage.sv
verilog/memWriteback.sv
verilog/execCore.sv
dv/execCore_chk.sv
dv/execCoreTb.sv
